//--- verilog/layer_cfg_pkg.sv
// Layer configuration for the squeeze stage, covering dimensions, fixed-point widths and biases.
`default_nettype none

package layer_cfg_pkg;

	localparam int NUM_LANES = 4; // parallel output channels.
	localparam int CHIN = 8; // input channels per pixel.
	localparam int NUM_PIX = 16; // pixels in one layer.

	localparam int PIX_W = 16; // pixel and weight width.
	localparam int ACC_W = 32; // accumulator width.
	localparam int FRAC_SHIFT = 14; // weights carry 14 fraction bits.

	localparam int CHAN_W = (CHIN > 1) ? $clog2(CHIN) : 1;
	localparam int PIX_IDX_W = (NUM_PIX > 1) ? $clog2(NUM_PIX) : 1;

	// weight image, lane major, so word lane*CHIN + chan is that lane's weight for chan.
	localparam string WEIGHT_FILE = "verilog/weights.hex";

	// per-lane bias in the accumulator's fixed-point scale, lane 0 is the rightmost entry.
	localparam logic [NUM_LANES-1:0][ACC_W-1:0] LANE_BIAS = {
		-32'sd32768, // lane 3.
		32'sd4096, // lane 2.
		-32'sd8192, // lane 1.
		32'sd16384 // lane 0.
	};

endpackage

`default_nettype wire

//--- verilog/cnn_types_pkg.sv
// Data and control types shared by the squeeze datapath and its controller.
`default_nettype none

package cnn_types_pkg;

	import layer_cfg_pkg::*;

	typedef logic signed [PIX_W-1:0] pix_t; // one channel value of a pixel.

	typedef logic [NUM_LANES-1:0][PIX_W-1:0] lane_vec_t; // one word per lane.

	typedef logic [NUM_LANES-1:0][ACC_W-1:0] acc_vec_t; // one accumulator per lane.

	// describes the input beat accepted in the current cycle.
	typedef struct packed {
		logic valid;
		logic first; // channel 0 of a pixel.
		logic last; // channel CHIN-1 of a pixel.
		logic [CHAN_W-1:0] chan;
		logic [PIX_IDX_W-1:0] pix;
	} beat_ctrl_t;

	// the accumulators hold a finished pixel while valid is set.
	typedef struct packed {
		logic valid;
		logic [PIX_IDX_W-1:0] pix;
	} acc_done_t;

	typedef struct packed {
		lane_vec_t data;
		logic [PIX_IDX_W-1:0] pix;
	} result_t;

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_RUN,
		ST_DRAIN,
		ST_DONE
	} ctrl_state_e;

endpackage

`default_nettype wire

//--- verilog/squeeze_ctrl.sv
// Layer FSM for the squeeze stage, which counts channels, pixels and results and paces the input.
`timescale 1ns/1ps
`default_nettype none

module squeeze_ctrl
	import cnn_types_pkg::*, layer_cfg_pkg::*;
(
	input logic clk,
	input logic arst_n,
	input logic start,
	input logic in_valid,
	output logic in_ready,
	input logic out_valid,
	input logic out_ready,
	input logic last_in_flight,
	output beat_ctrl_t beat,
	output logic [CHAN_W-1:0] rom_addr,
	output logic done
);

	ctrl_state_e state;
	logic [CHAN_W-1:0] chan_cnt;
	logic [PIX_IDX_W-1:0] pix_cnt;
	logic [PIX_IDX_W-1:0] res_cnt;
	logic start_ok;
	logic accept;
	logic chan_last;
	logic pix_last;
	logic res_take;
	logic res_last;
	logic out_stall;

	assign start_ok = start && ((state == ST_IDLE) || (state == ST_DONE));
	assign chan_last = (chan_cnt == CHAN_W'(CHIN - 1));
	assign pix_last = (pix_cnt == PIX_IDX_W'(NUM_PIX - 1));
	assign res_take = out_valid && out_ready;
	assign res_last = (res_cnt == PIX_IDX_W'(NUM_PIX - 1));
	assign out_stall = out_valid && !out_ready; // result register is full and held.

	// a finishing pixel must reach the result register before more input is taken.
	assign in_ready = (state == ST_RUN) && !last_in_flight && !out_stall;
	assign accept = in_valid && in_ready;

	always_comb begin
		beat.valid = accept;
		beat.first = accept && (chan_cnt == '0);
		beat.last = accept && chan_last;
		beat.chan = chan_cnt;
		beat.pix = pix_cnt;
	end

	assign rom_addr = chan_cnt; // the ROM row follows the channel being accepted.
	assign done = (state == ST_DONE);

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state <= ST_IDLE;
		end else begin
			case (state)
				ST_IDLE, ST_DONE: begin
					if (start) begin
						state <= ST_RUN;
					end
				end
				ST_RUN: begin
					if (accept && chan_last && pix_last) begin
						state <= ST_DRAIN; // all input of the layer is in.
					end
				end
				ST_DRAIN: begin
					if (res_take && res_last) begin
						state <= ST_DONE;
					end
				end
				default: begin
					state <= ST_IDLE;
				end
			endcase
		end
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			chan_cnt <= '0;
			pix_cnt <= '0;
			res_cnt <= '0;
		end else if (start_ok) begin
			chan_cnt <= '0;
			pix_cnt <= '0;
			res_cnt <= '0;
		end else begin
			if (accept) begin
				chan_cnt <= chan_last ? '0 : chan_cnt + 1'b1;
				if (chan_last) begin
					pix_cnt <= pix_last ? '0 : pix_cnt + 1'b1;
				end
			end
			if (res_take) begin
				res_cnt <= res_cnt + 1'b1; // delivered results, in pixel order.
			end
		end
	end

	a_ready_only_in_run: assert property (@(posedge clk) disable iff (!arst_n)
		in_ready |-> (state == ST_RUN))
		else $error("in_ready high outside ST_RUN");

	// a result can only be pending while its layer is still running.
	a_result_in_layer: assert property (@(posedge clk) disable iff (!arst_n)
		out_valid |-> ((state == ST_RUN) || (state == ST_DRAIN)))
		else $error("result pending outside a running layer");

endmodule

`default_nettype wire

//--- verilog/weight_rom.sv
// Weight ROM that returns all lane weights of one input channel per registered read.
`timescale 1ns/1ps
`default_nettype none

module weight_rom
	import cnn_types_pkg::*, layer_cfg_pkg::*;
(
	input logic clk,
	input logic [CHAN_W-1:0] rom_addr,
	output lane_vec_t weights
);

	logic [PIX_W-1:0] mem [NUM_LANES*CHIN]; // lane major image of the weight file.

	initial begin
		$readmemh(WEIGHT_FILE, mem);
	end

	// one row per channel, so every lane reads its own column in the same cycle.
	always_ff @(posedge clk) begin
		for (int l = 0; l < NUM_LANES; l++) begin
			weights[l] <= mem[l*CHIN + int'(rom_addr)];
		end
	end

endmodule

`default_nettype wire

//--- verilog/mac_array.sv
// Four-lane multiply-accumulate stage that sums channel products per pixel.
`timescale 1ns/1ps
`default_nettype none

module mac_array
	import cnn_types_pkg::*, layer_cfg_pkg::*;
(
	input logic clk,
	input logic arst_n,
	input beat_ctrl_t beat,
	input pix_t in_data,
	input lane_vec_t weights,
	output acc_vec_t acc_vec,
	output acc_done_t acc_done,
	output logic last_in_flight
);

	beat_ctrl_t s1_beat; // beat delayed to meet the ROM output.
	pix_t s1_data;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			s1_beat <= '0;
			acc_done <= '0;
		end else begin
			s1_beat <= beat;
			acc_done.valid <= s1_beat.valid && s1_beat.last;
			acc_done.pix <= s1_beat.pix;
		end
	end

	always_ff @(posedge clk) begin
		s1_data <= in_data;
	end

	// the controller relies on this to keep a second pixel from overtaking the first.
	assign last_in_flight = (s1_beat.valid && s1_beat.last) || acc_done.valid;

	genvar l;
	generate
		for (l = 0; l < NUM_LANES; l++) begin : g_lane
			logic signed [2*PIX_W-1:0] prod;
			logic signed [ACC_W-1:0] acc;

			assign prod = s1_data * $signed(weights[l]);

			always_ff @(posedge clk) begin
				if (s1_beat.valid) begin
					if (s1_beat.first) begin
						acc <= ACC_W'(prod); // a new pixel restarts the sum.
					end else begin
						acc <= acc + ACC_W'(prod);
					end
				end
			end

			assign acc_vec[l] = acc;
		end
	endgenerate

	// first must mark channel 0, and a single beat is both first and last only when CHIN is 1.
	a_first_last: assert property (@(posedge clk) disable iff (!arst_n)
		s1_beat.valid |-> (s1_beat.first == (s1_beat.chan == '0))
			&& (!(s1_beat.first && s1_beat.last) || (CHIN == 1)))
		else $error("inconsistent first/last marking on a beat");

endmodule

`default_nettype wire

//--- verilog/bias_relu_quant.sv
// Bias, ReLU and requantize stage with the output result register.
`timescale 1ns/1ps
`default_nettype none

module bias_relu_quant
	import cnn_types_pkg::*, layer_cfg_pkg::*;
(
	input logic clk,
	input logic arst_n,
	input acc_vec_t acc_vec,
	input acc_done_t acc_done,
	input logic out_ready,
	output logic out_valid,
	output result_t out_result
);

	lane_vec_t quant;

	genvar l;
	generate
		for (l = 0; l < NUM_LANES; l++) begin : g_lane
			logic signed [ACC_W-1:0] biased;

			assign biased = $signed(acc_vec[l]) + $signed(LANE_BIAS[l]);

			// negative sums clip to zero, the rest keep 15 bits above the fraction.
			assign quant[l] = biased[ACC_W-1] ? '0
				: {1'b0, biased[FRAC_SHIFT+PIX_W-2:FRAC_SHIFT]};
		end
	endgenerate

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			out_valid <= 1'b0;
		end else if (acc_done.valid) begin
			out_valid <= 1'b1;
		end else if (out_ready) begin
			out_valid <= 1'b0; // the held result was taken.
		end
	end

	always_ff @(posedge clk) begin
		if (acc_done.valid) begin
			out_result.data <= quant;
			out_result.pix <= acc_done.pix;
		end
	end

	// the input throttle upstream must keep a finished pixel away from a stalled result.
	a_no_overwrite: assert property (@(posedge clk) disable iff (!arst_n)
		acc_done.valid |-> !(out_valid && !out_ready))
		else $error("finished pixel arrived while the result was stalled");

endmodule

`default_nettype wire

//--- verilog/fire_squeeze_top.sv
// Top level of the 1x1 squeeze layer, joining the controller, weight ROM and datapath.
`timescale 1ns/1ps
`default_nettype none

module fire_squeeze_top
	import cnn_types_pkg::*, layer_cfg_pkg::*;
(
	input logic clk,
	input logic arst_n,
	input logic start,
	input logic in_valid,
	input pix_t in_data,
	input logic out_ready,
	output logic in_ready,
	output logic out_valid,
	output result_t out_result,
	output logic done
);

	beat_ctrl_t beat;
	logic [CHAN_W-1:0] rom_addr;
	lane_vec_t weights;
	acc_vec_t acc_vec;
	acc_done_t acc_done;
	logic last_in_flight;

	squeeze_ctrl u_ctrl (
		.clk (clk),
		.arst_n (arst_n),
		.start (start),
		.in_valid (in_valid),
		.in_ready (in_ready),
		.out_valid (out_valid),
		.out_ready (out_ready),
		.last_in_flight (last_in_flight),
		.beat (beat),
		.rom_addr (rom_addr),
		.done (done)
	);

	weight_rom u_rom (
		.clk (clk),
		.rom_addr (rom_addr),
		.weights (weights)
	);

	mac_array u_mac (
		.clk (clk),
		.arst_n (arst_n),
		.beat (beat),
		.in_data (in_data),
		.weights (weights),
		.acc_vec (acc_vec),
		.acc_done (acc_done),
		.last_in_flight (last_in_flight)
	);

	bias_relu_quant u_brq (
		.clk (clk),
		.arst_n (arst_n),
		.acc_vec (acc_vec),
		.acc_done (acc_done),
		.out_ready (out_ready),
		.out_valid (out_valid),
		.out_result (out_result)
	);

endmodule

`default_nettype wire

//--- tb/tb_fire_squeeze.sv
// Testbench for the 1x1 squeeze layer with a reference model, a result checker and timeouts.
`timescale 1ns/1ps
`default_nettype none

module tb_fire_squeeze
	import cnn_types_pkg::*, layer_cfg_pkg::*;
();

	localparam logic [31:0] SEED = 32'd21199;
	localparam int STALL_LIMIT = 400; // cycles any wait may take.

	typedef logic [CHIN-1:0][PIX_W-1:0] pix_chans_t; // all channels of one pixel.

	logic clk;
	logic arst_n;
	logic start;
	logic in_valid;
	pix_t in_data;
	logic out_ready;
	logic in_ready;
	logic out_valid;
	result_t out_result;
	logic done;

	logic [PIX_W-1:0] wmem [NUM_LANES*CHIN]; // same lane major image as the ROM.
	pix_chans_t pix_mem [NUM_PIX];
	int last_edge [NUM_PIX]; // cycle of the edge that took each pixel's last channel.
	logic [31:0] data_rng;
	logic [31:0] ready_rng;
	logic ready_random;
	lane_vec_t exp_data;
	int cyc = 0;
	int got = 0;
	int zero_lanes = 0;
	logic prev_valid = 1'b0;
	logic prev_stall = 1'b0;
	result_t prev_result = '0;

	fire_squeeze_top dut (
		.clk (clk),
		.arst_n (arst_n),
		.start (start),
		.in_valid (in_valid),
		.in_data (in_data),
		.out_ready (out_ready),
		.in_ready (in_ready),
		.out_valid (out_valid),
		.out_result (out_result),
		.done (done)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	always @(posedge clk) begin
		cyc <= cyc + 1;
	end

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	// signed dot product plus bias, then ReLU and bits 28 down to 14 of the sum.
	function automatic lane_vec_t expected_lanes(input pix_chans_t chans);
		lane_vec_t res;
		logic signed [63:0] sum;
		logic signed [63:0] a;
		logic signed [63:0] w;
		for (int l = 0; l < NUM_LANES; l++) begin
			sum = $signed(LANE_BIAS[l]);
			for (int c = 0; c < CHIN; c++) begin
				a = $signed(chans[c]);
				w = $signed(wmem[l*CHIN + c]);
				sum = sum + a * w;
			end
			res[l] = (sum < 0) ? '0 : {1'b0, sum[28:14]};
		end
		return res;
	endfunction

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("TB FAILED");
		$fatal(1, "simulation stopped at the first error");
	endtask

	task automatic report_mismatch(input string msg);
		abort_run($sformatf("[FAIL] t=%0t %s", $time, msg));
	endtask

	task automatic check_idle(input string phase);
		assert (!in_ready && !out_valid && !done)
			else report_mismatch($sformatf("%s in_ready=%b out_valid=%b done=%b",
				phase, in_ready, out_valid, done));
	endtask

	// random 14-bit pixels keep the 32-bit accumulator far from overflow.
	task automatic fill_layer(input int relu_pix);
		for (int p = 0; p < NUM_PIX; p++) begin
			for (int c = 0; c < CHIN; c++) begin
				data_rng = xorshift32(data_rng);
				pix_mem[p][c] = {{2{data_rng[13]}}, data_rng[13:0]};
				if (p == relu_pix) begin
					pix_mem[p][c] = 16'd4000; // drives lane 3 negative.
				end
			end
		end
	endtask

	task automatic send_layer();
		int p;
		int c;
		int stall;
		logic vld;
		p = 0;
		c = 0;
		stall = 0;
		vld = 1'b0;
		while (p < NUM_PIX) begin
			@(posedge clk);
			if (vld && in_ready) begin
				if (c == CHIN - 1) begin
					last_edge[p] = cyc;
					p++;
					c = 0;
				end else begin
					c++;
				end
				vld = 1'b0;
				stall = 0;
			end else begin
				stall++;
				if (stall > STALL_LIMIT) begin
					abort_run("timeout: the DUT stopped accepting input beats");
				end
			end
			if (!vld && (p < NUM_PIX)) begin
				data_rng = xorshift32(data_rng);
				vld = (data_rng[2:0] != 3'd0); // roughly one cycle in eight is a gap.
			end
			in_valid <= vld;
			if (p < NUM_PIX) begin
				in_data <= pix_mem[p][c];
			end
		end
	endtask

	task automatic run_layer(input int relu_pix);
		int waited;
		fill_layer(relu_pix);
		@(posedge clk);
		start <= 1'b1;
		@(posedge clk);
		start <= 1'b0;
		send_layer();
		waited = 0;
		while (!done) begin
			@(posedge clk);
			waited++;
			if (waited > STALL_LIMIT) begin
				abort_run("timeout: done did not rise after the layer was sent");
			end
		end
		in_valid <= 1'b1; // a beat offered in ST_DONE must not be taken.
		for (int i = 0; i < 4; i++) begin
			@(posedge clk);
		end
		in_valid <= 1'b0;
	endtask

	initial begin
		out_ready = 1'b0;
		ready_rng = xorshift32(SEED ^ 32'h0000_ffff); // second stream offset from the first.
		forever begin
			@(posedge clk);
			ready_rng = xorshift32(ready_rng);
			if (!arst_n) begin
				out_ready <= 1'b0;
			end else if (ready_random) begin
				out_ready <= ready_rng[0];
			end else begin
				out_ready <= 1'b1;
			end
		end
	end

	always @(posedge clk) begin
		if (arst_n) begin
			assert (done == (got == NUM_PIX))
				else report_mismatch($sformatf("done=%b after %0d results", done, got));
			assert (!(done && in_ready))
				else report_mismatch("in_ready is high while the layer is done");
			if (prev_stall) begin
				assert (out_valid && (out_result == prev_result))
					else report_mismatch("out_result changed while out_ready was low");
			end
			if (out_valid && out_ready) begin
				assert (got < NUM_PIX)
					else report_mismatch("result delivered past the end of the layer");
				exp_data = expected_lanes(pix_mem[got]);
				assert (out_result.pix == PIX_IDX_W'(got))
					else report_mismatch($sformatf("pixel index %0d, expected %0d",
						out_result.pix, got));
				assert (out_result.data == exp_data)
					else report_mismatch($sformatf("pixel %0d data %h, expected %h",
						got, out_result.data, exp_data));
				// valid rises at the second edge after the last channel and is taken at the third.
				if (!ready_random) begin
					assert (!prev_valid && (cyc - last_edge[got] == 3))
						else report_mismatch($sformatf("pixel %0d out_valid latency is off", got));
				end
				for (int l = 0; l < NUM_LANES; l++) begin
					if (out_result.data[l] == '0) begin
						zero_lanes++;
					end
				end
				got++;
			end
			if (start) begin
				got = 0;
			end
			prev_stall = out_valid && !out_ready;
			prev_valid = out_valid;
			prev_result = out_result;
		end
	end

	initial begin
		arst_n = 1'b0;
		start = 1'b0;
		in_valid = 1'b0;
		in_data = '0;
		ready_random = 1'b1;
		data_rng = SEED;
		$readmemh("verilog/weights.hex", wmem);
		for (int i = 0; i < 4; i++) begin
			@(posedge clk);
			check_idle("during reset");
		end
		arst_n <= 1'b1;
		for (int i = 0; i < 3; i++) begin
			@(posedge clk);
			check_idle("after reset");
		end
		run_layer(3);
		ready_random = 1'b0; // the second layer runs with the output always ready.
		run_layer(10);
		assert (zero_lanes > 0) begin
			$display("TB PASSED");
			$finish;
		end else begin
			abort_run("no lane was clamped to zero by ReLU during the run");
		end
	end

endmodule

`default_nettype wire

//--- flist.f
verilog/layer_cfg_pkg.sv
verilog/cnn_types_pkg.sv
verilog/squeeze_ctrl.sv
verilog/weight_rom.sv
verilog/mac_array.sv
verilog/bias_relu_quant.sv
verilog/fire_squeeze_top.sv
tb/tb_fire_squeeze.sv

//--- run.sh
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal --timescale 1ns/1ps \
	--top-module tb_fire_squeeze \
	--Mdir obj_dir \
	-f flist.f

# The printed verdict decides the outcome. The simulator status alone is not used.
sim_out="$(./obj_dir/Vtb_fire_squeeze 2>&1)" || true
printf '%s\n' "$sim_out"

if grep -qx "TB PASSED" <<< "$sim_out"; then
	exit 0
fi
exit 1

//--- verilog/weights.hex
// One signed 16-bit weight per line in lane major order.
// Lines 0 to 7 hold lane 0 for channels 0 to 7 and lane 1 follows.
4000
2000
f000
1000
0800
e000
3000
0400
c000
1800
2400
f800
0c00
1000
e800
2000
1000
1000
1000
1000
1000
1000
1000
1000
d000
e000
f000
0800
1000
f400
2800
c800
